//--- include/if_consts.svh
// Width, depth and field size constants for the instruction fetch stage
`ifndef IF_CONSTS_SVH
`define IF_CONSTS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Address and instruction word width
`define IF_XLEN 32

//////////////////////////////////////////////////
// Prefetch queueing
//////////////////////////////////////////////////

// Maximum fetches in flight, also response queue entries
`define IF_QUEUE_DEPTH 3

// Counter width, holds 0 up to IF_QUEUE_DEPTH
`define IF_CNT_W 2

//////////////////////////////////////////////////
// Trap vector fields
//////////////////////////////////////////////////

// mtvec base, bits [31:7] of the vector table address
`define IF_MTVEC_W 25

// Interrupt index used for vectored entry
`define IF_IRQ_IDX_W 5

`endif

//--- verilog/if_ctrl_pkg.sv
// Controller-side types: PC source enum, control command struct, target address struct
`default_nettype none

`include "if_consts.svh"

package if_ctrl_pkg;

  // Source of the next fetch address
  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_DRET     = 4'd4,
    PC_TRAP_EXC = 4'd5,
    PC_TRAP_IRQ = 4'd6,
    PC_TRAP_DBD = 4'd7,
    PC_TRAP_DBE = 4'd8
  } pc_mux_e;

  // Commands from the controller FSM to IF
  typedef struct packed {
    logic                     pc_set;
    pc_mux_e                  pc_mux;
    logic                     kill_if;
    logic                     halt_if;
    logic                     debug_mode_if;
    logic [`IF_IRQ_IDX_W-1:0] irq_index;
  } ctrl_fsm_t;

  // Candidate redirect addresses
  typedef struct packed {
    logic [`IF_XLEN-1:0]    boot_addr;
    logic [`IF_XLEN-1:0]    jump_target;
    logic [`IF_XLEN-1:0]    branch_target;
    logic [`IF_XLEN-1:0]    mepc;
    logic [`IF_XLEN-1:0]    dpc;
    logic [`IF_XLEN-1:0]    dm_halt_addr;
    logic [`IF_XLEN-1:0]    dm_exception_addr;
    logic [`IF_MTVEC_W-1:0] mtvec_addr;
  } if_targets_t;

endpackage

`default_nettype wire

//--- verilog/if_bus_pkg.sv
// Instruction bus request/response types and IF/ID pipeline register type
`default_nettype none

`include "if_consts.svh"

package if_bus_pkg;

  //////////////////////////////////////////////////
  // Instruction bus
  //////////////////////////////////////////////////

  // Request payload, held stable until granted
  typedef struct packed {
    logic [`IF_XLEN-1:0] addr;
    logic                dbg;
  } obi_req_t;

  // Response payload, qualified by rvalid
  typedef struct packed {
    logic [`IF_XLEN-1:0] rdata;
    logic                err;
  } obi_resp_t;

  // Returned word tagged with the address it was fetched from
  typedef struct packed {
    logic [`IF_XLEN-1:0] pc;
    obi_resp_t           resp;
  } inst_resp_t;

  //////////////////////////////////////////////////
  // IF/ID pipeline
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                instr_valid;
    logic [`IF_XLEN-1:0] pc;
    obi_resp_t           instr;
    // Debug trigger hits sampled with the instruction
    logic [`IF_XLEN-1:0] trigger_match;
    // Instruction will not execute, bus error or trigger
    logic                abort_op;
  } if_id_pipe_t;

endpackage

`default_nettype wire

//--- verilog/if_pc_select.sv
// Next fetch address mux over boot, jump, branch, return, trap and debug sources
`timescale 1ns/10ps
`default_nettype none

`include "if_consts.svh"

module if_pc_select (
  input  if_ctrl_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  if_ctrl_pkg::if_targets_t targets_i,
  output logic [`IF_XLEN-1:0]      branch_addr_o
);

  //////////////////////////////////////////////////
  // Address selection
  //////////////////////////////////////////////////

  always_comb begin
    // Boot address when nothing else matches
    branch_addr_o = {targets_i.boot_addr[`IF_XLEN-1:2], 2'b00};

    case (ctrl_fsm_i.pc_mux)
      if_ctrl_pkg::PC_BOOT:
        branch_addr_o = {targets_i.boot_addr[`IF_XLEN-1:2], 2'b00};
      // Word aligned fetch only, low bits dropped
      if_ctrl_pkg::PC_JUMP:
        branch_addr_o = {targets_i.jump_target[`IF_XLEN-1:2], 2'b00};
      if_ctrl_pkg::PC_BRANCH:
        branch_addr_o = {targets_i.branch_target[`IF_XLEN-1:2], 2'b00};
      // Return from trap
      if_ctrl_pkg::PC_MRET:
        branch_addr_o = {targets_i.mepc[`IF_XLEN-1:2], 2'b00};
      // Return from debug mode
      if_ctrl_pkg::PC_DRET:
        branch_addr_o = {targets_i.dpc[`IF_XLEN-1:2], 2'b00};
      // Exceptions share the vector base
      if_ctrl_pkg::PC_TRAP_EXC:
        branch_addr_o = {targets_i.mtvec_addr, 7'h00};
      // Vectored interrupts, one word per index
      if_ctrl_pkg::PC_TRAP_IRQ:
        branch_addr_o = {targets_i.mtvec_addr, ctrl_fsm_i.irq_index, 2'b00};
      // Debug entry
      if_ctrl_pkg::PC_TRAP_DBD:
        branch_addr_o = {targets_i.dm_halt_addr[`IF_XLEN-1:2], 2'b00};
      // Exception while in debug mode
      if_ctrl_pkg::PC_TRAP_DBE:
        branch_addr_o = {targets_i.dm_exception_addr[`IF_XLEN-1:2], 2'b00};
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Controller must never redirect with an undefined source
  always_comb begin
    if (ctrl_fsm_i.pc_set) begin
      a_pc_mux_known: assert (ctrl_fsm_i.pc_mux inside {
        if_ctrl_pkg::PC_BOOT,     if_ctrl_pkg::PC_JUMP,     if_ctrl_pkg::PC_BRANCH,
        if_ctrl_pkg::PC_MRET,     if_ctrl_pkg::PC_DRET,     if_ctrl_pkg::PC_TRAP_EXC,
        if_ctrl_pkg::PC_TRAP_IRQ, if_ctrl_pkg::PC_TRAP_DBD, if_ctrl_pkg::PC_TRAP_DBE})
        else $error("pc_set with unknown pc_mux %0h", ctrl_fsm_i.pc_mux);
    end
  end

endmodule

`default_nettype wire

//--- verilog/if_fetch_queue.sv
// Small circular FIFO with flush and a type parameter for its payload
`timescale 1ns/10ps
`default_nettype none

`include "if_consts.svh"

module if_fetch_queue #(
  parameter type item_t = logic [`IF_XLEN-1:0]
) (
  input  wire   clk,
  input  wire   rst_n,
  input  logic  flush_i,
  input  logic  push_i,
  input  item_t data_i,
  input  logic  pop_i,
  output item_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned DEPTH = `IF_QUEUE_DEPTH;

  // Storage and pointers
  item_t                mem_q [DEPTH];
  logic [`IF_CNT_W-1:0] wptr_q;
  logic [`IF_CNT_W-1:0] rptr_q;
  logic [`IF_CNT_W-1:0] cnt_q;
  logic                 push_en;
  logic                 pop_en;

  // Flush wins over both ports
  assign push_en = push_i && !flush_i;
  assign pop_en  = pop_i && !flush_i;

  assign full_o  = (cnt_q == `IF_CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  // Head of queue, only meaningful when not empty
  assign data_o  = mem_q[rptr_q];

  //////////////////////////////////////////////////
  // Pointer and count update
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      // Wrap at DEPTH, not a power of two
      if (push_en) begin
        wptr_q <= (wptr_q == `IF_CNT_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop_en) begin
        rptr_q <= (rptr_q == `IF_CNT_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (push_en && !pop_en) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_en && !push_en) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Entry write
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem_q[wptr_q] <= data_i;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_en |-> !full_o || pop_en)
    else $error("push into full fetch queue");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_en |-> !empty_o)
    else $error("pop from empty fetch queue");

endmodule

`default_nettype wire

//--- verilog/if_prefetcher.sv
// Prefetcher: bus request issue, outstanding tracking, redirect discard, response queue
`timescale 1ns/10ps
`default_nettype none

`include "if_consts.svh"

module if_prefetcher (
  input  wire                     clk,
  input  wire                     rst_n,
  input  if_ctrl_pkg::ctrl_fsm_t  ctrl_fsm_i,
  input  logic [`IF_XLEN-1:0]     branch_addr_i,
  input  logic                    prefetch_ready_i,
  output logic                    prefetch_valid_o,
  output if_bus_pkg::inst_resp_t  prefetch_instr_o,
  output logic                    instr_req_o,
  output if_bus_pkg::obi_req_t    instr_trans_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  if_bus_pkg::obi_resp_t   instr_resp_i,
  output logic                    busy_o
);

  // One extra bit so outstanding plus queued never wraps
  localparam int unsigned SUM_W = `IF_CNT_W + 1;

  // Fetch control state
  logic                   fetch_en_q;
  logic                   req_q;
  if_bus_pkg::obi_req_t   trans_q;
  logic [`IF_XLEN-1:0]    fetch_addr_q;
  logic [`IF_CNT_W-1:0]   out_cnt_q;
  logic [`IF_CNT_W-1:0]   discard_cnt_q;
  logic [`IF_CNT_W-1:0]   resp_cnt_q;

  // Next-state terms
  logic                   grant;
  logic                   req_free;
  logic                   redirect;
  logic                   flush;
  logic                   launch;
  logic [`IF_XLEN-1:0]    next_addr;
  logic [SUM_W-1:0]       out_nxt;
  logic [SUM_W-1:0]       resp_nxt;
  logic [`IF_CNT_W-1:0]   discard_nxt;

  // Queue handshakes
  logic                   resp_push;
  logic                   resp_pop;
  logic                   resp_empty;
  logic                   pc_empty;
  logic [`IF_XLEN-1:0]    resp_pc;
  if_bus_pkg::inst_resp_t resp_entry;

  assign grant    = req_q && instr_gnt_i;
  // Request slot is free when idle or handing off this cycle
  assign req_free = !req_q || instr_gnt_i;
  assign redirect = ctrl_fsm_i.pc_set;
  // Stale responses must not survive a redirect
  assign flush    = ctrl_fsm_i.kill_if || redirect;

  // Keep response only when no discards remain
  assign resp_push  = instr_rvalid_i && (discard_cnt_q == '0) && !flush;
  assign resp_pop   = prefetch_valid_o && prefetch_ready_i;
  assign resp_entry = '{pc: resp_pc, resp: instr_resp_i};

  //////////////////////////////////////////////////
  // Counters and launch decision
  //////////////////////////////////////////////////

  assign out_nxt  = SUM_W'(out_cnt_q) + SUM_W'(grant) - SUM_W'(instr_rvalid_i);
  assign resp_nxt = flush ? '0 :
                    SUM_W'(resp_cnt_q) + SUM_W'(resp_push) - SUM_W'(resp_pop);

  // Everything in flight, plus a still pending request, turns stale
  always_comb begin
    if (redirect) begin
      discard_nxt = out_cnt_q - `IF_CNT_W'(instr_rvalid_i) + `IF_CNT_W'(req_q);
    end else if (instr_rvalid_i && (discard_cnt_q != '0)) begin
      discard_nxt = discard_cnt_q - 1'b1;
    end else begin
      discard_nxt = discard_cnt_q;
    end
  end

  assign next_addr = redirect ? branch_addr_i : fetch_addr_q;

  // Stop once outstanding plus queued reaches the queue depth
  assign launch = (fetch_en_q || redirect) && req_free &&
                  ((out_nxt + resp_nxt) < SUM_W'(`IF_QUEUE_DEPTH));

  //////////////////////////////////////////////////
  // State registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q    <= 1'b0;
      req_q         <= 1'b0;
      fetch_addr_q  <= '0;
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
      resp_cnt_q    <= '0;
    end else begin
      // Idle until the first redirect
      fetch_en_q    <= fetch_en_q || redirect;
      out_cnt_q     <= out_nxt[`IF_CNT_W-1:0];
      discard_cnt_q <= discard_nxt;
      resp_cnt_q    <= resp_nxt[`IF_CNT_W-1:0];
      // Pending request is held until granted
      if (req_free) begin
        req_q <= launch;
      end
      fetch_addr_q  <= launch ? next_addr + `IF_XLEN'(4) : next_addr;
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (launch) begin
      trans_q.addr <= next_addr;
      trans_q.dbg  <= ctrl_fsm_i.debug_mode_if;
    end
  end

  assign instr_req_o   = req_q;
  assign instr_trans_o = trans_q;
  assign busy_o        = req_q || !pc_empty;

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  // PC of each granted fetch, popped on its response
  if_fetch_queue #(
    .item_t (logic [`IF_XLEN-1:0])
  ) pc_queue_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (1'b0),
    .push_i  (grant),
    .data_i  (trans_q.addr),
    .pop_i   (instr_rvalid_i),
    .data_o  (resp_pc),
    .full_o  (),
    .empty_o (pc_empty)
  );

  // Kept responses waiting for IF
  if_fetch_queue #(
    .item_t (if_bus_pkg::inst_resp_t)
  ) resp_queue_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush),
    .push_i  (resp_push),
    .data_i  (resp_entry),
    .pop_i   (resp_pop),
    .data_o  (prefetch_instr_o),
    .full_o  (),
    .empty_o (resp_empty)
  );

  assign prefetch_valid_o = !resp_empty;

  //////////////////////////////////////////////////
  // Bus checks
  //////////////////////////////////////////////////

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_trans_o)))
    else $error("instruction request changed before grant");

  a_rvalid_expected: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (out_cnt_q != '0))
    else $error("rvalid without outstanding fetch");

endmodule

`default_nettype wire

//--- verilog/if_stage.sv
// Instruction fetch stage top: PC select, prefetcher, abort logic and IF/ID register
`timescale 1ns/10ps
`default_nettype none

`include "if_consts.svh"

module if_stage (
  input  wire                      clk,
  input  wire                      rst_n,

  // Controller
  input  if_ctrl_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  if_ctrl_pkg::if_targets_t targets_i,
  input  logic [`IF_XLEN-1:0]      trigger_match_i,
  input  logic                     id_ready_i,

  // Instruction bus
  output logic                     instr_req_o,
  output if_bus_pkg::obi_req_t     instr_trans_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  if_bus_pkg::obi_resp_t    instr_resp_i,

  // Towards ID and CSR
  output if_bus_pkg::if_id_pipe_t  if_id_pipe_o,
  output logic [`IF_XLEN-1:0]      pc_if_o,
  output logic                     if_valid_o,
  output logic                     if_busy_o,
  output logic                     csr_mtvec_init_o,
  output logic                     abort_op_o
);

  logic [`IF_XLEN-1:0]    branch_addr;
  logic                   prefetch_valid;
  logic                   prefetch_ready;
  logic                   prefetch_busy;
  if_bus_pkg::inst_resp_t prefetch_instr;

  //////////////////////////////////////////////////
  // Fetch path
  //////////////////////////////////////////////////

  if_pc_select pc_select_i (
    .ctrl_fsm_i    (ctrl_fsm_i),
    .targets_i     (targets_i),
    .branch_addr_o (branch_addr)
  );

  if_prefetcher prefetcher_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_fsm_i       (ctrl_fsm_i),
    .branch_addr_i    (branch_addr),
    .prefetch_ready_i (prefetch_ready),
    .prefetch_valid_o (prefetch_valid),
    .prefetch_instr_o (prefetch_instr),
    .instr_req_o      (instr_req_o),
    .instr_trans_o    (instr_trans_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_resp_i     (instr_resp_i),
    .busy_o           (prefetch_busy)
  );

  // Offer to ID only when neither killed nor halted
  assign if_valid_o = prefetch_valid && !ctrl_fsm_i.kill_if && !ctrl_fsm_i.halt_if;

  // Drain on kill, otherwise follow ID unless halted
  assign prefetch_ready = ctrl_fsm_i.kill_if || (!ctrl_fsm_i.halt_if && id_ready_i);

  assign pc_if_o   = prefetch_instr.pc;
  assign if_busy_o = prefetch_busy;

  // Bus error or any trigger hit stops the instruction
  assign abort_op_o = prefetch_instr.resp.err || (|trigger_match_i);

  // mtvec init request on boot
  assign csr_mtvec_init_o = ctrl_fsm_i.pc_set &&
                            (ctrl_fsm_i.pc_mux == if_ctrl_pkg::PC_BOOT);

  //////////////////////////////////////////////////
  // IF/ID pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o <= '0;
    end else if (if_valid_o && id_ready_i) begin
      if_id_pipe_o.instr_valid   <= 1'b1;
      if_id_pipe_o.pc            <= pc_if_o;
      if_id_pipe_o.instr         <= prefetch_instr.resp;
      if_id_pipe_o.trigger_match <= trigger_match_i;
      if_id_pipe_o.abort_op      <= abort_op_o;
    end else if (id_ready_i) begin
      // ID took the last one and nothing new arrived
      if_id_pipe_o.instr_valid   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// Testbench clock source and power-on reset generator
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_ns  = 20,
  parameter int rst_cycles = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of cycles, released mid-cycle
  initial begin
    rst_n_o = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/tb_if_stage.sv
// IF stage testbench top: memory model, redirect stimulus table, IF/ID monitor, compare tasks
`timescale 1ns/10ps
`default_nettype none

`include "if_consts.svh"

module tb_if_stage;

  localparam int n_rows = 9;

  // Debug ROM window, fetched only while in debug mode
  localparam logic [`IF_XLEN-1:0] dbg_lo = 32'h0000_6800;
  localparam logic [`IF_XLEN-1:0] dbg_hi = 32'h0000_6FFF;

  // One redirect per row
  typedef struct packed {
    if_ctrl_pkg::pc_mux_e     src;
    logic [`IF_IRQ_IDX_W-1:0] irq;
    if_ctrl_pkg::if_targets_t targ;
    logic [`IF_XLEN-1:0]      exp_addr;
    logic [7:0]               rdy_pattern;
    logic                     halt;
    logic [`IF_XLEN-1:0]      trig;
    logic [`IF_XLEN-1:0]      err_lo;
    logic [`IF_XLEN-1:0]      err_hi;
  } stim_row_t;

  logic clk;
  logic rst_n;

  // DUT inputs
  if_ctrl_pkg::ctrl_fsm_t   ctrl_fsm      = '0;
  if_ctrl_pkg::if_targets_t targets       = '0;
  logic [`IF_XLEN-1:0]      trigger_match = '0;
  logic                     id_ready      = 1'b0;
  logic                     instr_gnt     = 1'b0;
  logic                     instr_rvalid  = 1'b0;
  if_bus_pkg::obi_resp_t    instr_resp    = '0;

  // DUT outputs
  logic                    instr_req;
  if_bus_pkg::obi_req_t    instr_trans;
  if_bus_pkg::if_id_pipe_t pipe;
  logic [`IF_XLEN-1:0]     pc_if;
  logic                    if_valid;
  logic                    if_busy;
  logic                    mtvec_init;
  logic                    abort_op;

  // Stimulus table and shared state
  stim_row_t                tbl [n_rows];
  if_ctrl_pkg::if_targets_t base_targ;
  int                       row_idx     = 0;
  logic [7:0]               rdy_pattern = 8'hFF;
  logic [2:0]               rdy_phase   = '0;
  int                       err_cnt     = 0;
  int                       timeout_cnt = 0;

  // Memory model state
  integer              seed = 32'h34f8_9808;
  logic [31:0]         rnd;
  logic [`IF_XLEN-1:0] mem_addr;
  logic [`IF_XLEN-1:0] pend_addr [$];
  int                  pend_due [$];
  int                  cyc;

  // Monitor state
  logic [`IF_XLEN-1:0]     exp_pc     = '0;
  logic [`IF_XLEN-1:0]     mon_lo     = '1;
  logic [`IF_XLEN-1:0]     mon_hi     = '0;
  logic [`IF_XLEN-1:0]     load_trig  = '0;
  logic                    load_seen  = 1'b0;
  logic                    stall_seen = 1'b0;
  if_bus_pkg::if_id_pipe_t snap;
  if_bus_pkg::obi_resp_t   exp_resp;
  int                      row_loads  = 0;

  tb_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  if_stage UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_fsm_i       (ctrl_fsm),
    .targets_i        (targets),
    .trigger_match_i  (trigger_match),
    .id_ready_i       (id_ready),
    .instr_req_o      (instr_req),
    .instr_trans_o    (instr_trans),
    .instr_gnt_i      (instr_gnt),
    .instr_rvalid_i   (instr_rvalid),
    .instr_resp_i     (instr_resp),
    .if_id_pipe_o     (pipe),
    .pc_if_o          (pc_if),
    .if_valid_o       (if_valid),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (mtvec_init),
    .abort_op_o       (abort_op)
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_resp(input string name, input if_bus_pkg::obi_resp_t got,
                            input if_bus_pkg::obi_resp_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got rdata=%h err=%b expected rdata=%h err=%b",
               $time, name, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_addr(input string name, input logic [`IF_XLEN-1:0] got,
                            input logic [`IF_XLEN-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Wait for n IF/ID loads in the current row
  task automatic wait_loads(input int n, input string what);
    int cycles;
    cycles = 0;
    while (row_loads < n && cycles < 400) begin
      @(posedge clk);
      cycles++;
    end
    if (row_loads < n) begin
      timeout_cnt++;
      $display("Timeout at %0t: %s delivered only %0d of %0d instructions",
               $time, what, row_loads, n);
    end
  endtask

  function automatic stim_row_t make_row(
    input if_ctrl_pkg::pc_mux_e     src,
    input logic [`IF_IRQ_IDX_W-1:0] irq,
    input logic [`IF_XLEN-1:0]      exp_addr,
    input logic [7:0]               rdy,
    input logic                     halt,
    input logic [`IF_XLEN-1:0]      trig,
    input logic [`IF_XLEN-1:0]      lo,
    input logic [`IF_XLEN-1:0]      hi
  );
    stim_row_t r;
    r.src         = src;
    r.irq         = irq;
    r.targ        = base_targ;
    r.exp_addr    = exp_addr;
    r.rdy_pattern = rdy;
    r.halt        = halt;
    r.trig        = trig;
    r.err_lo      = lo;
    r.err_hi      = hi;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  // Random grant, in-order response 1 to 3 cycles after grant
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
      instr_resp   <= '0;
      pend_addr.delete();
      pend_due.delete();
      cyc = 0;
    end else begin
      cyc++;
      if (instr_req && instr_gnt) begin
        // Requests into the debug ROM carry the debug flag
        check_flag("instr_trans_o.dbg", instr_trans.dbg,
                   (instr_trans.addr >= dbg_lo) && (instr_trans.addr <= dbg_hi));
        rnd = $random(seed);
        pend_addr.push_back(instr_trans.addr);
        pend_due.push_back(cyc + int'(rnd[4:0] % 5'd3));
      end
      rnd = $random(seed);
      instr_gnt <= rnd[1] | rnd[0];
      // Only the oldest fetch may answer
      if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
        mem_addr = pend_addr.pop_front();
        void'(pend_due.pop_front());
        instr_rvalid     <= 1'b1;
        instr_resp.rdata <= mem_addr ^ 32'hA5A5_0000;
        instr_resp.err   <= (mem_addr >= tbl[row_idx].err_lo) &&
                            (mem_addr <= tbl[row_idx].err_hi);
      end else begin
        instr_rvalid <= 1'b0;
        instr_resp   <= '0;
      end
    end
  end

  // ID back-pressure from a rotating pattern
  always @(posedge clk) begin
    rdy_phase <= rdy_phase + 3'd1;
    id_ready  <= rdy_pattern[rdy_phase];
  end

  //////////////////////////////////////////////////
  // IF/ID monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (load_seen) begin
        // New word expected at the next sequential pc
        exp_resp.rdata = exp_pc ^ 32'hA5A5_0000;
        exp_resp.err   = (exp_pc >= mon_lo) && (exp_pc <= mon_hi);
        check_flag("if_id_pipe_o.instr_valid", pipe.instr_valid, 1'b1);
        check_addr("if_id_pipe_o.pc", pipe.pc, exp_pc);
        check_resp("if_id_pipe_o.instr", pipe.instr, exp_resp);
        check_addr("if_id_pipe_o.trigger_match", pipe.trigger_match, load_trig);
        check_flag("if_id_pipe_o.abort_op", pipe.abort_op, exp_resp.err || (|load_trig));
        exp_pc = exp_pc + 32'd4;
        row_loads++;
      end else if (stall_seen) begin
        // ID stalled, register frozen
        check_flag("if_id_pipe_o.instr_valid", pipe.instr_valid, snap.instr_valid);
        check_addr("if_id_pipe_o.pc", pipe.pc, snap.pc);
        check_resp("if_id_pipe_o.instr", pipe.instr, snap.instr);
        check_flag("if_id_pipe_o.abort_op", pipe.abort_op, snap.abort_op);
      end else begin
        // ID was ready and nothing was offered
        check_flag("if_id_pipe_o.instr_valid", pipe.instr_valid, 1'b0);
      end
      if (ctrl_fsm.halt_if) begin
        check_flag("if_valid_o", if_valid, 1'b0);
      end
      // Redirect cycle, next load starts the new row
      if (ctrl_fsm.pc_set) begin
        exp_pc    = tbl[row_idx].exp_addr;
        mon_lo    = tbl[row_idx].err_lo;
        mon_hi    = tbl[row_idx].err_hi;
        row_loads = 0;
      end
      // Offered word is the next pc in sequence
      if (if_valid) begin
        check_addr("pc_if_o", pc_if, exp_pc);
        check_flag("abort_op_o", abort_op,
                   ((exp_pc >= mon_lo) && (exp_pc <= mon_hi)) || (|trigger_match));
      end
      // Busy while a request waits or a granted fetch has not answered
      check_flag("if_busy_o", if_busy,
                 instr_req || instr_rvalid || (pend_addr.size() != 0));
      load_seen  = if_valid && id_ready;
      stall_seen = !id_ready;
      load_trig  = trigger_match;
      snap       = pipe;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    int cycles;
    int i;

    base_targ.boot_addr         = 32'h0000_1003;
    base_targ.jump_target       = 32'h0000_2102;
    base_targ.branch_target     = 32'h0000_3041;
    base_targ.mepc              = 32'h0000_4400;
    base_targ.dpc               = 32'h0000_5803;
    base_targ.dm_halt_addr      = 32'h0000_6800;
    base_targ.dm_exception_addr = 32'h0000_6C02;
    // Vector table at 0x7000
    base_targ.mtvec_addr        = 25'h00_00E0;

    // Source, irq, address, ready pattern, halt, trigger, error window
    tbl[0] = make_row(if_ctrl_pkg::PC_BOOT, 5'd0, 32'h0000_1000, 8'hFF, 1'b0,
                      32'h0, 32'h0000_1008, 32'h0000_1008);
    tbl[1] = make_row(if_ctrl_pkg::PC_JUMP, 5'd0, 32'h0000_2100, 8'b1011_0110, 1'b0,
                      32'h0, 32'hFFFF_FFFF, 32'h0);
    tbl[2] = make_row(if_ctrl_pkg::PC_BRANCH, 5'd0, 32'h0000_3040, 8'hFF, 1'b1,
                      32'h0, 32'h0000_3050, 32'h0000_3054);
    tbl[3] = make_row(if_ctrl_pkg::PC_MRET, 5'd0, 32'h0000_4400, 8'b0110_1101, 1'b0,
                      32'h0000_0010, 32'hFFFF_FFFF, 32'h0);
    tbl[4] = make_row(if_ctrl_pkg::PC_DRET, 5'd0, 32'h0000_5800, 8'hFF, 1'b0,
                      32'h0, 32'h0000_5804, 32'h0000_580C);
    tbl[5] = make_row(if_ctrl_pkg::PC_TRAP_EXC, 5'd3, 32'h0000_7000, 8'b1110_0111, 1'b1,
                      32'h0, 32'hFFFF_FFFF, 32'h0);
    tbl[6] = make_row(if_ctrl_pkg::PC_TRAP_IRQ, 5'd5, 32'h0000_7014, 8'hFF, 1'b0,
                      32'h0, 32'h0000_7018, 32'h0000_7018);
    tbl[7] = make_row(if_ctrl_pkg::PC_TRAP_DBD, 5'd0, 32'h0000_6800, 8'b1001_1011, 1'b0,
                      32'h8000_0000, 32'hFFFF_FFFF, 32'h0);
    tbl[8] = make_row(if_ctrl_pkg::PC_TRAP_DBE, 5'd0, 32'h0000_6C00, 8'hFF, 1'b0,
                      32'h0, 32'hFFFF_FFFF, 32'h0);

    cycles = 0;
    while (!rst_n && cycles < 50) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      timeout_cnt++;
      $display("Timeout at %0t: reset was never released", $time);
    end

    // Idle after reset, nothing fetched before the first redirect
    repeat (6) begin
      @(negedge clk);
      check_flag("instr_req_o", instr_req, 1'b0);
      check_flag("if_id_pipe_o.instr_valid", pipe.instr_valid, 1'b0);
      check_flag("csr_mtvec_init_o", mtvec_init, 1'b0);
      check_flag("if_valid_o", if_valid, 1'b0);
      check_flag("if_busy_o", if_busy, 1'b0);
    end

    for (i = 0; i < n_rows; i++) begin
      @(posedge clk);
      row_idx       <= i;
      rdy_pattern   <= tbl[i].rdy_pattern;
      targets       <= tbl[i].targ;
      trigger_match <= tbl[i].trig;
      // Controller redirect kills the old stream
      ctrl_fsm.pc_set    <= 1'b1;
      ctrl_fsm.kill_if   <= 1'b1;
      ctrl_fsm.pc_mux    <= tbl[i].src;
      ctrl_fsm.irq_index <= tbl[i].irq;
      // Debug entry sources run in debug mode
      ctrl_fsm.debug_mode_if <= (tbl[i].src == if_ctrl_pkg::PC_TRAP_DBD) ||
                                (tbl[i].src == if_ctrl_pkg::PC_TRAP_DBE);
      @(negedge clk);
      check_flag("csr_mtvec_init_o", mtvec_init, tbl[i].src == if_ctrl_pkg::PC_BOOT);
      @(posedge clk);
      ctrl_fsm.pc_set  <= 1'b0;
      ctrl_fsm.kill_if <= 1'b0;
      wait_loads(3, "redirect");
      if (tbl[i].halt) begin
        ctrl_fsm.halt_if <= 1'b1;
        repeat (6) @(posedge clk);
        ctrl_fsm.halt_if <= 1'b0;
      end
      wait_loads(8, "sequential fetch");
    end

    repeat (4) @(posedge clk);
    $display("Summary: %0d value errors, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
verilog/if_ctrl_pkg.sv
verilog/if_bus_pkg.sv
verilog/if_pc_select.sv
verilog/if_fetch_queue.sv
verilog/if_prefetcher.sv
verilog/if_stage.sv
tb/tb_clk_gen.sv
tb/tb_if_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the IF stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_if_stage -f project.f -Mdir "$BUILD_DIR" -o tb_if_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/tb_if_stage_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG_FILE"; then
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG_FILE"; then
  echo "Simulation ended without a summary"
  exit 1
fi
exit 0
